// ==== compile.f ====
rtl/i2c_pkg.sv
rtl/i2c_xcvr_if.sv
rtl/i2c_reg_helper.sv
rtl/i2c_transceiver.sv
rtl/i2c_reg_master.sv
verif/i2c_slave_model.sv
verif/tb_i2c_reg_master.sv

// ==== rtl/i2c_pkg.sv ====
`default_nettype none

package i2c_pkg;

	//////////////////////////////////////////////////////////////////////
	// Widths

	localparam int BYTE_BITS = 8;	// One data byte on the bus

	//////////////////////////////////////////////////////////////////////
	// Byte-level command in progress at the transceiver

	typedef enum logic [2:0] {
		cmd_idle,
		cmd_start,		// Start, or repeated start if the bus is held
		cmd_restart,
		cmd_stop,
		cmd_tx,			// Send one byte, sample slave ack
		cmd_rx			// Receive one byte, drive ack/nack
	} xcvr_cmd_t;

	// Register helper sequencer
	typedef enum logic [3:0] {
		hs_idle,
		hs_open_idle,		// Session open, waiting for select or close
		hs_slave_addr_write,
		hs_reg_addr,
		hs_reg_addr_next,
		hs_slave_addr_read,
		hs_read_wait,
		hs_read_data,
		hs_write_wait,		// Waiting on client for wdata_valid
		hs_write_data,
		hs_stop,
		hs_stop_wait
	} helper_state_t;

	// Transceiver bit phases
	typedef enum logic [2:0] {
		xs_idle,
		xs_start,
		xs_bit_low,
		xs_bit_high,
		xs_ack_low,
		xs_ack_high,
		xs_stop
	} xcvr_state_t;

endpackage

`default_nettype wire

// ==== rtl/i2c_reg_helper.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_reg_helper #(
	parameter int ADDR_BYTES = 1
) (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire  [6:0]                           slave_addr,
	input  wire                                  open,
	input  wire                                  select,
	input  wire  [i2c_pkg::BYTE_BITS*ADDR_BYTES-1:0] addr,
	input  wire                                  we,
	input  wire  [7:0]                           burst_len,
	input  wire                                  close,
	input  wire                                  wdata_valid,
	input  wire  [i2c_pkg::BYTE_BITS-1:0]        wdata,
	output logic                                 ready,
	output logic                                 done,
	output logic                                 rdata_valid,
	output logic [i2c_pkg::BYTE_BITS-1:0]        rdata,
	output logic                                 err,		// Sticky nack flag
	output logic                                 need_wdata,
	i2c_xcvr_if.helper                           xcvr
);

	localparam int ADDR_SIZE = i2c_pkg::BYTE_BITS * ADDR_BYTES;
	localparam int ACNT_W    = $clog2(ADDR_BYTES + 1);

	i2c_pkg::helper_state_t  state;
	i2c_pkg::xcvr_cmd_t      cmd_issued;	// Command pulse currently on the interface
	logic [ADDR_SIZE-1:0]    saved_addr;	// Register address, MSB byte on top
	logic [ACNT_W-1:0]       addr_left;		// Address bytes still to send
	logic [7:0]              bytes_left;	// Burst countdown
	logic                    we_r;
	logic                    tx_pend;		// A sent byte whose ack is not yet checked
	logic                    xcvr_free;

	// Which command is in flight this cycle
	always_comb begin
		if (xcvr.start_en)
			cmd_issued = i2c_pkg::cmd_start;
		else if (xcvr.restart_en)
			cmd_issued = i2c_pkg::cmd_restart;
		else if (xcvr.stop_en)
			cmd_issued = i2c_pkg::cmd_stop;
		else if (xcvr.tx_en)
			cmd_issued = i2c_pkg::cmd_tx;
		else if (xcvr.rx_en)
			cmd_issued = i2c_pkg::cmd_rx;
		else
			cmd_issued = i2c_pkg::cmd_idle;
	end

	// busy only rises a cycle after the pulse, so hold off while one is out
	assign xcvr_free = !xcvr.busy && (cmd_issued == i2c_pkg::cmd_idle);

	always_ff @(posedge clk) begin
		if (reset) begin
			state           <= i2c_pkg::hs_idle;
			ready           <= 1'b0;
			done            <= 1'b0;
			rdata_valid     <= 1'b0;
			need_wdata      <= 1'b0;
			err             <= 1'b0;
			tx_pend         <= 1'b0;
			addr_left       <= '0;
			bytes_left      <= '0;
			we_r            <= 1'b0;
			xcvr.tx_en      <= 1'b0;
			xcvr.rx_en      <= 1'b0;
			xcvr.start_en   <= 1'b0;
			xcvr.restart_en <= 1'b0;
			xcvr.stop_en    <= 1'b0;
		end else begin
			done            <= 1'b0;	// Pulses default low
			rdata_valid     <= 1'b0;
			need_wdata      <= 1'b0;
			xcvr.tx_en      <= 1'b0;
			xcvr.rx_en      <= 1'b0;
			xcvr.start_en   <= 1'b0;
			xcvr.restart_en <= 1'b0;
			xcvr.stop_en    <= 1'b0;

			// Check ack of the last byte sent once it has finished
			if (xcvr_free && tx_pend) begin
				tx_pend <= 1'b0;
				if (!xcvr.tx_ack)
					err <= 1'b1;
			end

			case (state)

				//////////////////////////////////////////////////////////////////////
				// Session control

				i2c_pkg::hs_idle: begin
					if (open) begin
						ready <= 1'b1;
						err   <= 1'b0;		// New session, forget old nacks
						state <= i2c_pkg::hs_open_idle;
					end
				end

				i2c_pkg::hs_open_idle: begin
					if (select) begin
						ready         <= 1'b0;
						xcvr.start_en <= 1'b1;	// Repeated start if bus still held
						saved_addr    <= addr;
						addr_left     <= ACNT_W'(ADDR_BYTES);
						bytes_left    <= burst_len;
						we_r          <= we;
						state         <= i2c_pkg::hs_slave_addr_write;
					end else if (close) begin
						ready <= 1'b0;
						state <= i2c_pkg::hs_stop;
					end
				end

				//////////////////////////////////////////////////////////////////////
				// Header: device address and register address

				i2c_pkg::hs_slave_addr_write: begin
					if (xcvr_free) begin
						xcvr.tx_en   <= 1'b1;
						xcvr.tx_data <= {slave_addr, 1'b0};
						tx_pend      <= 1'b1;
						state        <= i2c_pkg::hs_reg_addr;
					end
				end

				i2c_pkg::hs_reg_addr: begin
					if (xcvr_free) begin
						xcvr.tx_en   <= 1'b1;
						xcvr.tx_data <= saved_addr[ADDR_SIZE-1 -: i2c_pkg::BYTE_BITS];
						tx_pend      <= 1'b1;
						saved_addr   <= saved_addr << i2c_pkg::BYTE_BITS;	// Next byte up
						addr_left    <= addr_left - 1'b1;
						state        <= i2c_pkg::hs_reg_addr_next;
					end
				end

				i2c_pkg::hs_reg_addr_next: begin
					if (xcvr_free) begin
						if (addr_left != '0) begin
							state <= i2c_pkg::hs_reg_addr;
						end else if (bytes_left == 8'd0) begin
							ready <= 1'b1;		// Empty burst, address only
							state <= i2c_pkg::hs_open_idle;
						end else if (!we_r) begin
							xcvr.restart_en <= 1'b1;
							state           <= i2c_pkg::hs_slave_addr_read;
						end else begin
							need_wdata <= 1'b1;
							state      <= i2c_pkg::hs_write_wait;
						end
					end
				end

				i2c_pkg::hs_slave_addr_read: begin
					if (xcvr_free) begin
						xcvr.tx_en   <= 1'b1;
						xcvr.tx_data <= {slave_addr, 1'b1};
						tx_pend      <= 1'b1;
						state        <= i2c_pkg::hs_read_wait;
					end
				end

				//////////////////////////////////////////////////////////////////////
				// Read burst

				i2c_pkg::hs_read_wait: begin
					if (xcvr_free) begin
						xcvr.rx_en  <= 1'b1;
						xcvr.rx_ack <= (bytes_left != 8'd1);	// Nack the last byte
						state       <= i2c_pkg::hs_read_data;
					end
				end

				i2c_pkg::hs_read_data: begin
					if (xcvr.rx_rdy) begin
						rdata_valid <= 1'b1;
						rdata       <= xcvr.rx_out;
						bytes_left  <= bytes_left - 1'b1;
						if (bytes_left == 8'd1) begin
							ready <= 1'b1;
							state <= i2c_pkg::hs_open_idle;
						end else begin
							state <= i2c_pkg::hs_read_wait;
						end
					end
				end

				//////////////////////////////////////////////////////////////////////
				// Write burst

				i2c_pkg::hs_write_wait: begin
					if (wdata_valid) begin		// Client may take any time
						xcvr.tx_en   <= 1'b1;
						xcvr.tx_data <= wdata;
						tx_pend      <= 1'b1;
						state        <= i2c_pkg::hs_write_data;
					end
				end

				i2c_pkg::hs_write_data: begin
					if (xcvr_free) begin
						bytes_left <= bytes_left - 1'b1;
						if (bytes_left == 8'd1) begin
							ready <= 1'b1;
							state <= i2c_pkg::hs_open_idle;
						end else begin
							need_wdata <= 1'b1;
							state      <= i2c_pkg::hs_write_wait;
						end
					end
				end

				// Close: stop condition, then done
				i2c_pkg::hs_stop: begin
					if (xcvr_free) begin
						xcvr.stop_en <= 1'b1;
						state        <= i2c_pkg::hs_stop_wait;
					end
				end

				i2c_pkg::hs_stop_wait: begin
					if (xcvr_free) begin
						done  <= 1'b1;
						state <= i2c_pkg::hs_idle;
					end
				end

				default: state <= i2c_pkg::hs_idle;

			endcase
		end
	end

	// Client only selects inside an open, idle session
	select_needs_ready: assert property (
		@(posedge clk) disable iff (reset) select |-> ready
	);

	// Command pulses never overlap a transceiver operation
	no_cmd_while_busy: assert property (
		@(posedge clk) disable iff (reset)
		(cmd_issued != i2c_pkg::cmd_idle) |-> !xcvr.busy
	);

endmodule

`default_nettype wire

// ==== rtl/i2c_reg_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_reg_master #(
	parameter int ADDR_BYTES = 1,	// Register address width in bytes
	parameter int CLK_DIV    = 8	// clk cycles per SCL quarter
) (
	input  wire                                  clk,
	input  wire                                  reset,
	input  wire  [6:0]                           slave_addr,
	input  wire                                  open,
	input  wire                                  select,
	input  wire  [i2c_pkg::BYTE_BITS*ADDR_BYTES-1:0] addr,
	input  wire                                  we,
	input  wire  [7:0]                           burst_len,
	input  wire                                  close,
	input  wire                                  wdata_valid,
	input  wire  [i2c_pkg::BYTE_BITS-1:0]        wdata,
	output logic                                 ready,
	output logic                                 done,
	output logic                                 rdata_valid,
	output logic [i2c_pkg::BYTE_BITS-1:0]        rdata,
	output logic                                 err,
	output logic                                 need_wdata,
	output logic                                 scl,
	output logic                                 sda_oe,
	input  wire                                  sda_in
);

	i2c_xcvr_if xcvr_if ();		// Byte commands, helper to transceiver

	// Register transaction sequencer
	i2c_reg_helper #(
		.ADDR_BYTES (ADDR_BYTES)
	) i2c_reg_helper_i (
		.clk         (clk),
		.reset       (reset),
		.slave_addr  (slave_addr),
		.open        (open),
		.select      (select),
		.addr        (addr),
		.we          (we),
		.burst_len   (burst_len),
		.close       (close),
		.wdata_valid (wdata_valid),
		.wdata       (wdata),
		.ready       (ready),
		.done        (done),
		.rdata_valid (rdata_valid),
		.rdata       (rdata),
		.err         (err),
		.need_wdata  (need_wdata),
		.xcvr        (xcvr_if.helper)
	);

	// Bit engine on the pins
	i2c_transceiver #(
		.CLK_DIV (CLK_DIV)
	) i2c_transceiver_i (
		.clk    (clk),
		.reset  (reset),
		.xcvr   (xcvr_if.transceiver),
		.scl    (scl),
		.sda_oe (sda_oe),
		.sda_in (sda_in)
	);

endmodule

`default_nettype wire

// ==== rtl/i2c_transceiver.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_transceiver #(
	parameter int CLK_DIV = 8	// clk cycles per SCL quarter period
) (
	input  wire                clk,
	input  wire                reset,
	i2c_xcvr_if.transceiver    xcvr,
	output logic               scl,
	output logic               sda_oe,	// 1 pulls SDA low
	input  wire                sda_in
);

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam int MSB   = i2c_pkg::BYTE_BITS - 1;

	i2c_pkg::xcvr_state_t           state;
	i2c_pkg::xcvr_cmd_t             op;		// Operation in progress
	i2c_pkg::xcvr_cmd_t             new_cmd;
	logic [CNT_W-1:0]               qcnt;
	logic                           tick;		// End of a quarter period
	logic [1:0]                     qtr;		// Quarter within the current bit
	logic [2:0]                     bit_cnt;
	logic [i2c_pkg::BYTE_BITS-1:0]  shreg;		// Shared tx/rx shifter
	logic                           rx_ack_r;

	// Decode incoming pulse
	always_comb begin
		if (xcvr.start_en)
			new_cmd = i2c_pkg::cmd_start;
		else if (xcvr.restart_en)
			new_cmd = i2c_pkg::cmd_restart;
		else if (xcvr.stop_en)
			new_cmd = i2c_pkg::cmd_stop;
		else if (xcvr.tx_en)
			new_cmd = i2c_pkg::cmd_tx;
		else if (xcvr.rx_en)
			new_cmd = i2c_pkg::cmd_rx;
		else
			new_cmd = i2c_pkg::cmd_idle;
	end

	//////////////////////////////////////////////////////////////////////
	// Quarter-period divider, runs only while a command is active

	assign tick = (qcnt == CNT_W'(CLK_DIV - 1));

	always_ff @(posedge clk) begin
		if (reset || state == i2c_pkg::xs_idle || tick)
			qcnt <= '0;
		else
			qcnt <= qcnt + 1'b1;
	end

	//////////////////////////////////////////////////////////////////////
	// Bit phase FSM, actions happen at the end of each quarter

	always_ff @(posedge clk) begin
		if (reset) begin
			state       <= i2c_pkg::xs_idle;
			op          <= i2c_pkg::cmd_idle;
			qtr         <= '0;
			bit_cnt     <= '0;
			scl         <= 1'b1;	// Bus released
			sda_oe      <= 1'b0;
			xcvr.busy   <= 1'b0;
			xcvr.rx_rdy <= 1'b0;
			xcvr.tx_ack <= 1'b0;
		end else begin
			xcvr.rx_rdy <= 1'b0;
			if (tick)
				qtr <= qtr + 1'b1;

			case (state)

				i2c_pkg::xs_idle: begin
					if (new_cmd != i2c_pkg::cmd_idle) begin
						op        <= new_cmd;
						xcvr.busy <= 1'b1;
						qtr       <= '0;
						bit_cnt   <= 3'd7;
						case (new_cmd)
							i2c_pkg::cmd_start, i2c_pkg::cmd_restart:
								state <= i2c_pkg::xs_start;
							i2c_pkg::cmd_stop:
								state <= i2c_pkg::xs_stop;
							i2c_pkg::cmd_tx: begin
								shreg <= xcvr.tx_data;
								state <= i2c_pkg::xs_bit_low;
							end
							default: begin		// Receive
								rx_ack_r <= xcvr.rx_ack;
								state    <= i2c_pkg::xs_bit_low;
							end
						endcase
					end
				end

				// Release SDA, raise SCL, then SDA falls with SCL high.
				// On a held bus this is the repeated start.
				i2c_pkg::xs_start: begin
					if (tick) begin
						case (qtr)
							2'd0: sda_oe <= 1'b0;
							2'd1: scl    <= 1'b1;
							2'd2: sda_oe <= 1'b1;	// Start condition
							default: begin
								scl       <= 1'b0;	// Hold bus for the header
								xcvr.busy <= 1'b0;
								op        <= i2c_pkg::cmd_idle;
								state     <= i2c_pkg::xs_idle;
							end
						endcase
					end
				end

				i2c_pkg::xs_stop: begin
					if (tick) begin
						case (qtr)
							2'd0: begin
								if (!scl)
									sda_oe <= 1'b1;	// Low before SCL rises
							end
							2'd1: scl    <= 1'b1;
							2'd2: sda_oe <= 1'b0;	// Stop condition
							default: begin
								xcvr.busy <= 1'b0;
								op        <= i2c_pkg::cmd_idle;
								state     <= i2c_pkg::xs_idle;
							end
						endcase
					end
				end

				// Data bits, MSB first
				i2c_pkg::xs_bit_low: begin
					if (tick) begin
						if (qtr == 2'd0) begin
							sda_oe <= (op == i2c_pkg::cmd_tx) && !shreg[MSB];
						end else begin
							scl   <= 1'b1;
							state <= i2c_pkg::xs_bit_high;
						end
					end
				end

				i2c_pkg::xs_bit_high: begin
					if (tick) begin
						if (qtr == 2'd2) begin
							shreg <= {shreg[MSB-1:0], sda_in};	// Sample mid-high
						end else begin
							scl <= 1'b0;
							if (bit_cnt == 3'd0) begin
								state <= i2c_pkg::xs_ack_low;
							end else begin
								bit_cnt <= bit_cnt - 1'b1;
								state   <= i2c_pkg::xs_bit_low;
							end
						end
					end
				end

				// Ninth bit: slave acks our byte, or we ack theirs
				i2c_pkg::xs_ack_low: begin
					if (tick) begin
						if (qtr == 2'd0) begin
							sda_oe <= (op == i2c_pkg::cmd_rx) && rx_ack_r;
						end else begin
							scl   <= 1'b1;
							state <= i2c_pkg::xs_ack_high;
						end
					end
				end

				i2c_pkg::xs_ack_high: begin
					if (tick) begin
						if (qtr == 2'd2) begin
							if (op == i2c_pkg::cmd_tx)
								xcvr.tx_ack <= !sda_in;
						end else begin
							scl       <= 1'b0;
							xcvr.busy <= 1'b0;
							if (op == i2c_pkg::cmd_rx) begin
								xcvr.rx_rdy <= 1'b1;
								xcvr.rx_out <= shreg;
							end
							op    <= i2c_pkg::cmd_idle;
							state <= i2c_pkg::xs_idle;
						end
					end
				end

				default: state <= i2c_pkg::xs_idle;

			endcase
		end
	end

	one_cmd_at_a_time: assert property (
		@(posedge clk) disable iff (reset)
		$onehot0({xcvr.tx_en, xcvr.rx_en, xcvr.start_en, xcvr.restart_en, xcvr.stop_en})
	);

	// SDA moves under a low SCL except for start and stop conditions
	sda_only_while_scl_low: assert property (
		@(posedge clk) disable iff (reset)
		($changed(sda_oe) && state != i2c_pkg::xs_start && state != i2c_pkg::xs_stop)
			|-> (!scl && !$past(scl))
	);

endmodule

`default_nettype wire

// ==== rtl/i2c_xcvr_if.sv ====
`timescale 1ns/1ps
`default_nettype none

interface i2c_xcvr_if;

	// Helper to transceiver, all pulses one cycle wide
	logic                            tx_en;
	logic [i2c_pkg::BYTE_BITS-1:0]   tx_data;	// Valid with tx_en
	logic                            rx_en;
	logic                            rx_ack;	// 1 = ack the received byte
	logic                            start_en;
	logic                            restart_en;
	logic                            stop_en;

	// Transceiver to helper
	logic                            busy;		// High the cycle after a pulse until done
	logic                            rx_rdy;	// Pulse, rx_out valid
	logic [i2c_pkg::BYTE_BITS-1:0]   rx_out;
	logic                            tx_ack;	// Level, 1 = slave acked last byte

	modport helper (
		output tx_en, tx_data, rx_en, rx_ack, start_en, restart_en, stop_en,
		input  busy, rx_rdy, rx_out, tx_ack
	);

	modport transceiver (
		input  tx_en, tx_data, rx_en, rx_ack, start_en, restart_en, stop_en,
		output busy, rx_rdy, rx_out, tx_ack
	);

endinterface

`default_nettype wire

// ==== verif/i2c_slave_model.sv ====
`timescale 1ns/1ps
`default_nettype none

module i2c_slave_model #(
	parameter int         ADDR_BYTES = 1,
	parameter logic [6:0] DEV_ADDR   = 7'h50
) (
	input  wire scl,
	inout  wire sda,
	output int  read_count,	// Bytes sent since the last start
	output int  nack_at,	// Byte the master nacked, 0 if none
	output int  stop_count
);

	typedef enum {sl_idle, sl_dev, sl_addr, sl_write, sl_read} slave_state_t;

	logic [7:0]   mem [256];
	slave_state_t state;
	int           bit_cnt;		// SCL pulse within the 9-bit frame
	int           addr_left;
	logic [7:0]   shift;
	logic [7:0]   ptr;			// Auto-incrementing register pointer
	logic         rw;
	logic         sda_low;
	logic         master_nack;

	assign sda = sda_low ? 1'b0 : 1'bz;	// Open drain

	initial begin
		for (int i = 0; i < 256; i++)
			mem[i] = i[7:0] ^ 8'h5A;	// Power-up contents
		state       = sl_idle;
		bit_cnt     = 0;
		sda_low     = 1'b0;
		master_nack = 1'b0;
		read_count  = 0;
		nack_at     = 0;
		stop_count  = 0;
	end

	//////////////////////////////////////////////////////////////////////
	// Bus conditions

	// Start or repeated start
	always @(negedge sda) begin
		if (scl === 1'b1) begin
			state       = sl_dev;
			bit_cnt     = -1;		// Skip the SCL fall that ends the start
			sda_low     = 1'b0;
			master_nack = 1'b0;
			read_count  = 0;
			nack_at     = 0;
		end
	end

	always @(posedge sda) begin
		if (scl === 1'b1) begin	// Stop
			state      = sl_idle;
			sda_low    = 1'b0;
			stop_count = stop_count + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Bit handling

	always @(posedge scl) begin
		if (state != sl_idle && bit_cnt >= 0) begin
			if (bit_cnt < 8 && state != sl_read) begin
				shift = {shift[6:0], sda};
			end else if (bit_cnt == 8 && state == sl_read) begin
				read_count = read_count + 1;
				if (sda === 1'b1) begin	// Master ends the burst
					master_nack = 1'b1;
					nack_at     = read_count;
				end
			end
		end
	end

	always @(negedge scl) begin
		if (state == sl_idle) begin
			sda_low = 1'b0;
		end else if (bit_cnt == 7) begin	// Ack slot next
			bit_cnt = 8;
			case (state)
				sl_dev: begin
					if (shift[7:1] == DEV_ADDR) begin
						rw      = shift[0];
						sda_low = 1'b1;
					end else begin
						state = sl_idle;	// Someone else's address
					end
				end
				sl_addr: begin
					ptr       = shift;	// Upper address bytes fall outside the map
					addr_left = addr_left - 1;
					sda_low   = 1'b1;
				end
				sl_write: begin
					mem[ptr] = shift;
					ptr      = ptr + 1'b1;
					sda_low  = 1'b1;
				end
				default: sda_low = 1'b0;	// Read, master answers
			endcase
		end else if (bit_cnt == 8) begin	// Frame over
			bit_cnt = 0;
			sda_low = 1'b0;
			case (state)
				sl_dev: begin
					addr_left = ADDR_BYTES;
					state     = rw ? sl_read : sl_addr;
				end
				sl_addr: begin
					if (addr_left == 0)
						state = sl_write;
				end
				sl_read: begin
					if (master_nack)
						state = sl_idle;
				end
				default: ;
			endcase
			if (state == sl_read) begin	// Load next byte, first bit out now
				shift   = mem[ptr];
				ptr     = ptr + 1'b1;
				sda_low = !shift[7];
			end
		end else begin
			bit_cnt = bit_cnt + 1;
			if (state == sl_read)
				sda_low = !shift[7 - bit_cnt];
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_i2c_reg_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_reg_master;

	localparam int ADDR_BYTES  = 1;
	localparam int CLK_DIV     = 4;
	localparam int PERIOD      = 40;
	localparam int NROWS       = 7;
	localparam int MAX_BURST   = 4;
	localparam int BYTE_CYCLES = 40 * CLK_DIV;	// Byte plus ack, with slack
	localparam int WATCHDOG_CYCLES = NROWS * MAX_BURST * BYTE_CYCLES
		+ NROWS * 6 * BYTE_CYCLES + 2000;		// Headers, stops, reset

	logic                                     clk;
	logic                                     reset;
	logic [6:0]                               slave_addr;
	logic                                     open;
	logic                                     select;
	logic [i2c_pkg::BYTE_BITS*ADDR_BYTES-1:0] addr;
	logic                                     we;
	logic [7:0]                               burst_len;
	logic                                     close;
	logic                                     wdata_valid;
	logic [i2c_pkg::BYTE_BITS-1:0]            wdata;
	logic                                     ready;
	logic                                     done;
	logic                                     rdata_valid;
	logic [i2c_pkg::BYTE_BITS-1:0]            rdata;
	logic                                     err;
	logic                                     need_wdata;
	logic                                     scl;
	logic                                     sda_oe;
	tri1                                      sda;		// Pull-up
	int                                       slave_reads;
	int                                       slave_nack_at;
	int                                       slave_stops;

	// Stimulus table, one row per transaction
	logic [6:0]                               row_slave [NROWS];
	logic                                     row_we    [NROWS];
	logic [i2c_pkg::BYTE_BITS*ADDR_BYTES-1:0] row_addr  [NROWS];
	int                                       row_len   [NROWS];
	logic [i2c_pkg::BYTE_BITS-1:0]            row_data  [NROWS][MAX_BURST];
	logic                                     row_err   [NROWS];	// Nobody answers
	logic                                     row_close [NROWS];	// Ends its session
	logic [i2c_pkg::BYTE_BITS-1:0]            shadow    [256];
	int                                       seed;
	int                                       value_errors;
	int                                       missing_events;
	logic                                     session_err;

	assign sda = sda_oe ? 1'b0 : 1'bz;

	i2c_reg_master #(
		.ADDR_BYTES (ADDR_BYTES),
		.CLK_DIV    (CLK_DIV)
	) i2c_reg_master_i (
		.clk         (clk),
		.reset       (reset),
		.slave_addr  (slave_addr),
		.open        (open),
		.select      (select),
		.addr        (addr),
		.we          (we),
		.burst_len   (burst_len),
		.close       (close),
		.wdata_valid (wdata_valid),
		.wdata       (wdata),
		.ready       (ready),
		.done        (done),
		.rdata_valid (rdata_valid),
		.rdata       (rdata),
		.err         (err),
		.need_wdata  (need_wdata),
		.scl         (scl),
		.sda_oe      (sda_oe),
		.sda_in      (sda)
	);

	i2c_slave_model #(
		.ADDR_BYTES (ADDR_BYTES),
		.DEV_ADDR   (7'h50)
	) slave_i (
		.scl        (scl),
		.sda        (sda),
		.read_count (slave_reads),
		.nack_at    (slave_nack_at),
		.stop_count (slave_stops)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	//////////////////////////////////////////////////////////////////////
	// Compare tasks

	task automatic compare_byte(input logic [i2c_pkg::BYTE_BITS-1:0] got,
		input logic [i2c_pkg::BYTE_BITS-1:0] exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %h, expected %h", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
			value_errors++;
		end
	endtask

	task automatic verify_count(input int got, input int exp, input string what);
		if (got != exp) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, exp);
			value_errors++;
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Table and client sequences

	task automatic add_row(input int r, input logic [6:0] sa, input logic w,
		input logic [i2c_pkg::BYTE_BITS*ADDR_BYTES-1:0] a, input int len,
		input logic bad, input logic last);
		logic [i2c_pkg::BYTE_BITS-1:0] b;
		row_slave[r] = sa;
		row_we[r]    = w;
		row_addr[r]  = a;
		row_len[r]   = len;
		row_err[r]   = bad;
		row_close[r] = last;
		for (int k = 0; k < len; k++) begin
			if (w) begin
				b = $random(seed);
				row_data[r][k] = b;
				if (!bad)
					shadow[(a + k) % 256] = b;	// Slave auto-increments
			end else begin
				row_data[r][k] = shadow[(a + k) % 256];
			end
		end
	endtask

	task automatic open_session();
		@(posedge clk);
		open <= 1'b1;
		@(posedge clk);
		open <= 1'b0;
		@(posedge clk);		// ready one cycle after open
		check_flag(ready, 1'b1, "ready after open");
		check_flag(err, 1'b0, "err after open");
		session_err = 1'b0;
	endtask

	task automatic run_row(input int r, output logic ok);
		int cycles;
		int limit;
		int reads;
		int needs;
		int delay;
		cycles = 0;
		reads  = 0;
		needs  = 0;
		limit  = (row_len[r] + 6) * BYTE_CYCLES + 8 * row_len[r];
		ok     = 1'b1;
		@(posedge clk);
		slave_addr <= row_slave[r];
		addr       <= row_addr[r];
		we         <= row_we[r];
		burst_len  <= 8'(row_len[r]);
		select     <= 1'b1;
		@(posedge clk);
		select <= 1'b0;
		forever begin
			@(posedge clk);
			cycles++;
			if (rdata_valid) begin
				if (reads < row_len[r])
					compare_byte(rdata, row_data[r][reads], "read data");
				reads++;
			end
			if (need_wdata) begin	// Client answers late
				delay = $unsigned($random(seed)) % 5;
				repeat (delay) @(posedge clk);
				wdata_valid <= 1'b1;
				wdata       <= row_data[r][needs % MAX_BURST];
				@(posedge clk);
				wdata_valid <= 1'b0;
				needs++;
				cycles += delay + 1;
			end
			if (ready === 1'b1 || cycles >= limit)
				break;
		end
		if (ready !== 1'b1) begin
			$display("Transaction %0d: ready did not return within %0d cycles", r, limit);
			missing_events++;
			ok = 1'b0;
		end else begin
			session_err = session_err | row_err[r];	// Sticky until next open
			check_flag(err, session_err, "err after transaction");
			if (row_we[r]) begin
				verify_count(needs, row_len[r], "need_wdata pulses");
			end else if (reads < row_len[r]) begin
				$display("Transaction %0d: only %0d of %0d read bytes arrived",
					r, reads, row_len[r]);
				missing_events++;
			end else begin
				verify_count(reads, row_len[r], "rdata_valid pulses");
				if (!row_err[r]) begin
					verify_count(slave_reads, row_len[r], "bytes sent by slave");
					verify_count(slave_nack_at, row_len[r], "byte nacked by master");
				end
			end
		end
	endtask

	task automatic close_session(output logic ok);
		int cycles;
		int stops;
		int extra;
		stops  = slave_stops;
		cycles = 0;
		extra  = 0;
		ok     = 1'b1;
		@(posedge clk);
		close <= 1'b1;
		@(posedge clk);
		close <= 1'b0;
		forever begin
			@(posedge clk);
			cycles++;
			if (done === 1'b1 || cycles >= 2 * BYTE_CYCLES)
				break;
		end
		if (done !== 1'b1) begin
			$display("done did not pulse within %0d cycles of close", 2 * BYTE_CYCLES);
			missing_events++;
			ok = 1'b0;
		end else begin
			verify_count(slave_stops, stops + 1, "stop conditions before done");
			repeat (8) begin
				@(posedge clk);
				if (done)
					extra++;
			end
			verify_count(extra, 0, "extra done pulses");
		end
	endtask

	//////////////////////////////////////////////////////////////////////
	// Main sequence

	initial begin : main
		logic ok;
		logic in_session;
		seed           = 17436;
		value_errors   = 0;
		missing_events = 0;
		session_err    = 1'b0;
		in_session     = 1'b0;
		ok             = 1'b1;
		reset       <= 1'b1;
		slave_addr  <= 7'h50;
		open        <= 1'b0;
		select      <= 1'b0;
		addr        <= '0;
		we          <= 1'b0;
		burst_len   <= '0;
		close       <= 1'b0;
		wdata_valid <= 1'b0;
		wdata       <= '0;
		for (int i = 0; i < 256; i++)
			shadow[i] = i[7:0] ^ 8'h5A;		// Slave power-up contents

		add_row(0, 7'h50, 1'b1, 8'h10, 1, 1'b0, 1'b0);	// Single write
		add_row(1, 7'h50, 1'b0, 8'h10, 1, 1'b0, 1'b1);	// Read it back
		add_row(2, 7'h50, 1'b1, 8'h20, 4, 1'b0, 1'b1);	// Burst write
		add_row(3, 7'h50, 1'b0, 8'h20, 4, 1'b0, 1'b1);
		add_row(4, 7'h50, 1'b0, 8'h23, 2, 1'b0, 1'b0);	// Crosses into untouched memory
		add_row(5, 7'h3A, 1'b1, 8'h05, 1, 1'b1, 1'b1);	// No device here
		add_row(6, 7'h50, 1'b0, 8'h05, 1, 1'b0, 1'b1);

		repeat (16) @(posedge clk);
		reset <= 1'b0;
		@(posedge clk);
		check_flag(ready, 1'b0, "ready after reset");
		check_flag(done, 1'b0, "done after reset");
		check_flag(rdata_valid, 1'b0, "rdata_valid after reset");
		check_flag(need_wdata, 1'b0, "need_wdata after reset");
		check_flag(err, 1'b0, "err after reset");
		check_flag(scl, 1'b1, "scl after reset");
		check_flag(sda_oe, 1'b0, "sda_oe after reset");

		for (int r = 0; r < NROWS && ok; r++) begin
			if (!in_session) begin
				open_session();
				in_session = 1'b1;
			end
			run_row(r, ok);
			if (ok && row_close[r]) begin
				close_session(ok);
				in_session = 1'b0;
			end
		end

		$display("Errors: %0d wrong values, %0d missing events", value_errors, missing_events);
		if (value_errors == 0 && missing_events == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	initial begin : watchdog
		i2c_pkg::helper_state_t hs;
		#(WATCHDOG_CYCLES * PERIOD);
		hs = i2c_reg_master_i.i2c_reg_helper_i.state;
		$display("Run did not finish within %0d cycles, helper stuck in state %s",
			WATCHDOG_CYCLES, hs.name());
		$display("Simulation FAILED");
		$finish;
	end

endmodule

`default_nettype wire
